// ==== cnn_cfg_pkg.sv ====
// ------------------
// Array geometry, memory sizes and layer select shared by the conv engine
// ------------------

package cnn_cfg_pkg;

    // MAC row and weight banks
    localparam int NUM_LANES = 16;
    localparam int L1_LANES  = 6;
    localparam int LANE_W    = 4;

    // 5x5 window
    localparam int TAP_CNT   = 25;
    localparam int TAP_IDX_W = 5;

    // Bank memories, layer 2 weights start after the layer 1 block
    localparam int W_ADDR_W  = 6;
    localparam int W_DEPTH   = 64;
    localparam int L2_BASE   = 25;

    localparam int DATA_W    = 8;
    localparam int ACC_W     = 24;

    // Lanes 0..5 in layer 1
    localparam logic [NUM_LANES-1:0] L1_MASK = NUM_LANES'((1 << L1_LANES) - 1);

    typedef enum logic {
        LAYER_1 = 1'b0,
        LAYER_2 = 1'b1
    } layer_e;

endpackage

// ==== cnn_cmd_pkg.sv ====
// ------------------
// Host command word layout and opcodes
// ------------------

package cnn_cmd_pkg;

    localparam int CMD_W = 20;

    typedef enum logic [1:0] {
        OP_LOAD_W = 2'd0,
        OP_LOAD_A = 2'd1,
        OP_START  = 2'd2
    } cmd_op_e;

    // Weight and activation loads, tap index sits in addr for OP_LOAD_A
    typedef struct packed {
        cmd_op_e                          op;
        logic [cnn_cfg_pkg::LANE_W-1:0]   bank;
        logic [cnn_cfg_pkg::W_ADDR_W-1:0] addr;
        logic [cnn_cfg_pkg::DATA_W-1:0]   data;
    } cmd_load_t;

    typedef struct packed {
        cmd_op_e             op;
        cnn_cfg_pkg::layer_e layer;
        logic [CMD_W-4:0]    rsvd;
    } cmd_start_t;

    // Opcode bits overlap in both views
    typedef union packed {
        cmd_load_t  ld;
        cmd_start_t st;
    } cmd_word_u;

endpackage

// ==== cnn_ifs.sv ====
// ------------------
// Bank write port and weight tap stream between the engine blocks
// ------------------

`timescale 1ns/1ps

interface wmem_wr_if;
    import cnn_cfg_pkg::*;

    logic                wr_en;
    logic [LANE_W-1:0]   wr_bank;
    logic [W_ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0]   wr_data;

    modport src (output wr_en, wr_bank, wr_addr, wr_data);
    modport dst (input wr_en, wr_bank, wr_addr, wr_data);
endinterface

// No ready, the sweep runs at full rate
interface tap_if;
    import cnn_cfg_pkg::*;

    logic                                tap_valid;
    logic                                tap_first;
    logic                                tap_last;
    logic [TAP_IDX_W-1:0]                tap_idx;
    logic [NUM_LANES-1:0]                lane_en;
    logic [NUM_LANES-1:0][DATA_W-1:0]    weights;

    modport src (output tap_valid, tap_first, tap_last, tap_idx, lane_en, weights);
    modport dst (input tap_valid, tap_first, tap_last, tap_idx, lane_en, weights);
endinterface

// ==== cmd_decoder.sv ====
// ------------------
// Accepts host commands and routes loads and starts into the engine
// ------------------

`timescale 1ns/1ps

module cmd_decoder (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  cmd_valid_i,
    output logic                                  cmd_ready_o,
    input  cnn_cmd_pkg::cmd_word_u                cmd_word_i,
    input  logic                                  drain_busy_i,
    input  logic                                  sweep_busy_i,
    wmem_wr_if.src                                wr,
    output logic                                  act_we_o,
    output logic [cnn_cfg_pkg::TAP_IDX_W-1:0]     act_idx_o,
    output logic [cnn_cfg_pkg::DATA_W-1:0]        act_data_o,
    output logic                                  start_o,
    output cnn_cfg_pkg::layer_e                   layer_o
);
    import cnn_cfg_pkg::*;
    import cnn_cmd_pkg::*;

    logic    rdy_q;
    logic    busy_q;
    logic    cmd_acc;
    cmd_op_e op;

    assign op          = cmd_word_i.ld.op;
    assign cmd_ready_o = rdy_q && !busy_q;
    assign cmd_acc     = cmd_valid_i && cmd_ready_o;

    // Start goes straight to the weight buffer in the accept cycle
    assign start_o = cmd_acc && (op == OP_START);
    assign layer_o = cmd_word_i.st.layer;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdy_q     <= 1'b0;
            busy_q    <= 1'b0;
            wr.wr_en  <= 1'b0;
            act_we_o  <= 1'b0;
        end else begin
            rdy_q     <= 1'b1;
            busy_q    <= start_o || (busy_q && (drain_busy_i || sweep_busy_i));
            wr.wr_en  <= cmd_acc && (op == OP_LOAD_W);
            act_we_o  <= cmd_acc && (op == OP_LOAD_A);
        end
    end

    always_ff @(posedge clk) begin
        wr.wr_bank <= cmd_word_i.ld.bank;
        wr.wr_addr <= cmd_word_i.ld.addr;
        wr.wr_data <= cmd_word_i.ld.data;
        act_idx_o  <= cmd_word_i.ld.addr[TAP_IDX_W-1:0];
        act_data_o <= cmd_word_i.ld.data;
    end

    // Host must stay inside bank depth and the 5x5 window
    a_load_range: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_acc && (op == OP_LOAD_W || op == OP_LOAD_A) |->
            (op == OP_LOAD_W && int'(cmd_word_i.ld.addr) < W_DEPTH) ||
            (op == OP_LOAD_A && int'(cmd_word_i.ld.addr) < TAP_CNT))
        else $error("[FAIL] a_load_range op=%0h addr=%0h", op, cmd_word_i.ld.addr);

endmodule

// ==== weight_banks.sv ====
// ------------------
// Sixteen weight memories, shared write port, registered reads
// ------------------

`timescale 1ns/1ps

module weight_banks (
    input  logic                                                          clk,
    wmem_wr_if.dst                                                        wr,
    input  logic [cnn_cfg_pkg::NUM_LANES-1:0]                             rd_en_i,
    input  logic [cnn_cfg_pkg::NUM_LANES-1:0][cnn_cfg_pkg::W_ADDR_W-1:0]  rd_addr_i,
    output logic [cnn_cfg_pkg::NUM_LANES-1:0][cnn_cfg_pkg::DATA_W-1:0]    rd_data_o
);
    import cnn_cfg_pkg::*;

    for (genvar b = 0; b < NUM_LANES; b++) begin : g_bank
        logic [DATA_W-1:0] mem [W_DEPTH];
        logic [DATA_W-1:0] rd_q;

        always_ff @(posedge clk) begin
            if (wr.wr_en && wr.wr_bank == LANE_W'(b)) begin
                mem[wr.wr_addr] <= wr.wr_data;
            end
            // Output holds while the bank is not read
            if (rd_en_i[b]) begin
                rd_q <= mem[rd_addr_i[b]];
            end
        end

        assign rd_data_o[b] = rd_q;
    end

endmodule

// ==== weight_buffer.sv ====
// ------------------
// Sweeps bank addresses for one pass and streams the weights as taps
// ------------------

`timescale 1ns/1ps

module weight_buffer (
    input  logic                                                          clk,
    input  logic                                                          rst_n,
    input  logic                                                          start_i,
    input  cnn_cfg_pkg::layer_e                                           layer_i,
    output logic [cnn_cfg_pkg::NUM_LANES-1:0]                             rd_en_o,
    output logic [cnn_cfg_pkg::NUM_LANES-1:0][cnn_cfg_pkg::W_ADDR_W-1:0]  rd_addr_o,
    input  logic [cnn_cfg_pkg::NUM_LANES-1:0][cnn_cfg_pkg::DATA_W-1:0]    rd_data_i,
    output logic                                                          busy_o,
    tap_if.src                                                            tap
);
    import cnn_cfg_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_L1,
        S_L2
    } state_e;

    state_e               state, state_n;
    logic [TAP_IDX_W-1:0] cnt, cnt_n;
    logic                 sweeping;
    logic                 cnt_end;
    logic [W_ADDR_W-1:0]  addr;

    // Tap attributes, stage 1 beside the address, stage 2 beside bank data
    logic                 s1_valid, s2_valid;
    logic                 s1_first, s2_first;
    logic                 s1_last, s2_last;
    logic [TAP_IDX_W-1:0] s1_idx, s2_idx;
    logic [NUM_LANES-1:0] s2_mask;

    assign sweeping = state != S_IDLE;
    assign cnt_end  = cnt == TAP_IDX_W'(TAP_CNT - 1);
    assign addr     = (state == S_L2) ? W_ADDR_W'(cnt) + W_ADDR_W'(L2_BASE) : W_ADDR_W'(cnt);

    always_comb begin
        state_n = state;
        cnt_n   = cnt;
        case (state)
            S_IDLE: begin
                cnt_n = '0;
                if (start_i) begin
                    state_n = (layer_i == LAYER_2) ? S_L2 : S_L1;
                end
            end
            default: begin
                cnt_n = cnt + 1'b1;
                if (cnt_end) begin
                    state_n = S_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= S_IDLE;
            cnt           <= '0;
            rd_en_o       <= '0;
            s1_valid      <= 1'b0;
            s2_valid      <= 1'b0;
            tap.tap_valid <= 1'b0;
        end else begin
            state         <= state_n;
            cnt           <= cnt_n;
            rd_en_o       <= !sweeping ? '0 : (state == S_L2) ? '1 : L1_MASK;
            s1_valid      <= sweeping;
            s2_valid      <= s1_valid;
            tap.tap_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        rd_addr_o     <= {NUM_LANES{addr}};
        s1_first      <= cnt == '0;
        s1_last       <= cnt_end;
        s1_idx        <= cnt;
        s2_first      <= s1_first;
        s2_last       <= s1_last;
        s2_idx        <= s1_idx;
        s2_mask       <= rd_en_o;
        tap.tap_first <= s2_first;
        tap.tap_last  <= s2_last;
        tap.tap_idx   <= s2_idx;
        tap.lane_en   <= s2_mask;
        tap.weights   <= rd_data_i;
    end

    // Busy until the last tap has left the pipeline
    assign busy_o = sweeping || s1_valid || s2_valid || tap.tap_valid;

    a_lane_mask: assert property (@(posedge clk) disable iff (!rst_n)
        tap.tap_valid |-> (tap.lane_en == L1_MASK || tap.lane_en == '1))
        else $error("[FAIL] a_lane_mask lane_en=%0h", tap.lane_en);

endmodule

// ==== mac_array.sv ====
// ------------------
// Activation window and sixteen signed MAC lanes fed by the tap stream
// ------------------

`timescale 1ns/1ps

module mac_array (
    input  logic                                                        clk,
    input  logic                                                        rst_n,
    input  logic                                                        act_we_i,
    input  logic [cnn_cfg_pkg::TAP_IDX_W-1:0]                           act_idx_i,
    input  logic [cnn_cfg_pkg::DATA_W-1:0]                              act_data_i,
    tap_if.dst                                                          tap,
    output logic                                                        sums_valid_o,
    output logic [cnn_cfg_pkg::NUM_LANES-1:0][cnn_cfg_pkg::ACC_W-1:0]   sums_o,
    output logic [cnn_cfg_pkg::LANE_W:0]                                lane_cnt_o
);
    import cnn_cfg_pkg::*;

    logic signed [DATA_W-1:0] act_q [TAP_CNT];
    logic signed [DATA_W-1:0] act_cur;
    logic signed [ACC_W-1:0]  acc_q [NUM_LANES];
    logic signed [ACC_W-1:0]  acc_nx [NUM_LANES];

    always_ff @(posedge clk) begin
        if (act_we_i) begin
            act_q[act_idx_i] <= act_data_i;
        end
    end

    assign act_cur = act_q[tap.tap_idx];

    // First tap restarts the sum, idle lanes keep their value
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            acc_nx[l] = tap.tap_first ? '0 : acc_q[l];
            if (tap.lane_en[l]) begin
                acc_nx[l] = acc_nx[l] + $signed(tap.weights[l]) * act_cur;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tap.tap_valid) begin
            acc_q <= acc_nx;
        end
        if (tap.tap_valid && tap.tap_last) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                sums_o[l] <= acc_nx[l];
            end
            lane_cnt_o <= (LANE_W + 1)'($countones(tap.lane_en));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sums_valid_o <= 1'b0;
        end else begin
            sums_valid_o <= tap.tap_valid && tap.tap_last;
        end
    end

endmodule

// ==== result_drain.sv ====
// ------------------
// Sends the latched lane sums one by one over valid/ready
// ------------------

`timescale 1ns/1ps

module result_drain (
    input  logic                                                        clk,
    input  logic                                                        rst_n,
    input  logic                                                        sums_valid_i,
    input  logic [cnn_cfg_pkg::NUM_LANES-1:0][cnn_cfg_pkg::ACC_W-1:0]   sums_i,
    input  logic [cnn_cfg_pkg::LANE_W:0]                                lane_cnt_i,
    output logic                                                        busy_o,
    output logic                                                        res_valid_o,
    input  logic                                                        res_ready_i,
    output logic [cnn_cfg_pkg::LANE_W-1:0]                              res_lane_o,
    output logic [cnn_cfg_pkg::ACC_W-1:0]                               res_data_o
);
    import cnn_cfg_pkg::*;

    logic [NUM_LANES-1:0][ACC_W-1:0] sums_q;
    logic [LANE_W:0]                 cnt_q;
    logic [LANE_W-1:0]               lane_q;
    logic                            xfer;
    logic                            last_lane;

    assign xfer      = res_valid_o && res_ready_i;
    assign last_lane = (LANE_W + 1)'(lane_q) + 1'b1 == cnt_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid_o <= 1'b0;
            lane_q      <= '0;
        end else if (sums_valid_i) begin
            res_valid_o <= 1'b1;
            lane_q      <= '0;
        end else if (xfer) begin
            res_valid_o <= !last_lane;
            lane_q      <= lane_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (sums_valid_i) begin
            sums_q <= sums_i;
            cnt_q  <= lane_cnt_i;
        end
    end

    assign res_lane_o = lane_q;
    assign res_data_o = sums_q[lane_q];

    // Covers the cycle between the latch pulse and the first valid
    assign busy_o = res_valid_o || sums_valid_i;

    a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid_o && !res_ready_i |=>
            res_valid_o && $stable(res_data_o) && $stable(res_lane_o))
        else $error("[FAIL] a_res_hold lane=%0h data=%0h", res_lane_o, res_data_o);

endmodule

// ==== cnn_conv_top.sv ====
// ------------------
// Convolution engine top, host command port in and result port out
// ------------------

`timescale 1ns/1ps

module cnn_conv_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              cmd_valid_i,
    output logic                              cmd_ready_o,
    input  logic [cnn_cmd_pkg::CMD_W-1:0]     cmd_word_i,
    output logic                              res_valid_o,
    input  logic                              res_ready_i,
    output logic [cnn_cfg_pkg::LANE_W-1:0]    res_lane_o,
    output logic [cnn_cfg_pkg::ACC_W-1:0]     res_data_o
);
    import cnn_cfg_pkg::*;

    logic                                start;
    layer_e                              layer;
    logic                                act_we;
    logic [TAP_IDX_W-1:0]                act_idx;
    logic [DATA_W-1:0]                   act_data;
    logic [NUM_LANES-1:0]                rd_en;
    logic [NUM_LANES-1:0][W_ADDR_W-1:0]  rd_addr;
    logic [NUM_LANES-1:0][DATA_W-1:0]    rd_data;
    logic                                sweep_busy;
    logic                                drain_busy;
    logic                                sums_valid;
    logic [NUM_LANES-1:0][ACC_W-1:0]     sums;
    logic [LANE_W:0]                     lane_cnt;

    wmem_wr_if i_wmem_wr ();
    tap_if     i_tap ();

    cmd_decoder i_cmd_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_ready_o  (cmd_ready_o),
        .cmd_word_i   (cmd_word_i),
        .drain_busy_i (drain_busy),
        .sweep_busy_i (sweep_busy),
        .wr           (i_wmem_wr.src),
        .act_we_o     (act_we),
        .act_idx_o    (act_idx),
        .act_data_o   (act_data),
        .start_o      (start),
        .layer_o      (layer)
    );

    weight_banks i_weight_banks (
        .clk       (clk),
        .wr        (i_wmem_wr.dst),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    weight_buffer i_weight_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start),
        .layer_i   (layer),
        .rd_en_o   (rd_en),
        .rd_addr_o (rd_addr),
        .rd_data_i (rd_data),
        .busy_o    (sweep_busy),
        .tap       (i_tap.src)
    );

    mac_array i_mac_array (
        .clk          (clk),
        .rst_n        (rst_n),
        .act_we_i     (act_we),
        .act_idx_i    (act_idx),
        .act_data_i   (act_data),
        .tap          (i_tap.dst),
        .sums_valid_o (sums_valid),
        .sums_o       (sums),
        .lane_cnt_o   (lane_cnt)
    );

    result_drain i_result_drain (
        .clk          (clk),
        .rst_n        (rst_n),
        .sums_valid_i (sums_valid),
        .sums_i       (sums),
        .lane_cnt_i   (lane_cnt),
        .busy_o       (drain_busy),
        .res_valid_o  (res_valid_o),
        .res_ready_i  (res_ready_i),
        .res_lane_o   (res_lane_o),
        .res_data_o   (res_data_o)
    );

endmodule

// ==== tb_cnn_conv.sv ====
// ------------------
// Testbench for the conv engine: loads weights and a window, runs layer 1
// and layer 2 passes, checks results against a software model
// ------------------

`timescale 1ns/1ps

module tb_cnn_conv;
    import cnn_cfg_pkg::*;
    import cnn_cmd_pkg::*;

    localparam int N_PASSES  = 4;
    localparam int LOAD_CYC  = NUM_LANES * 2 * TAP_CNT + TAP_CNT + 16;
    localparam int PASS_CYC  = 29 + NUM_LANES * 8 + 8;
    localparam int LIMIT_CYC = LOAD_CYC + N_PASSES * PASS_CYC + 200;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 cmd_valid_i;
    logic                 cmd_ready_o;
    logic [CMD_W-1:0]     cmd_word_i;
    logic                 res_valid_o;
    logic                 res_ready_i;
    logic [LANE_W-1:0]    res_lane_o;
    logic [ACC_W-1:0]     res_data_o;

    // Software copy of the banks and the activation window
    logic [DATA_W-1:0]    w_mem [NUM_LANES][2*TAP_CNT];
    logic [DATA_W-1:0]    act_mem [TAP_CNT];
    logic [ACC_W-1:0]     exp_sum [NUM_LANES];
    int                   exp_cnt = 0;
    int                   exp_idx;
    int                   rx_cnt;
    logic                 pass_busy;
    logic                 rand_ready = 1'b0;
    logic                 start_acc;
    logic [31:0]          data_rng = 32'h68ff;
    logic [31:0]          rdy_rng = 32'h68ff;
    int                   err_data = 0;
    int                   err_proto = 0;

    cnn_conv_top i_cnn_conv_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid_i (cmd_valid_i),
        .cmd_ready_o (cmd_ready_o),
        .cmd_word_i  (cmd_word_i),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_lane_o  (res_lane_o),
        .res_data_o  (res_data_o)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [CMD_W-1:0] load_word(cmd_op_e op, int bank, int addr,
                                                   logic [DATA_W-1:0] data);
        cmd_word_u w;
        w.ld.op   = op;
        w.ld.bank = LANE_W'(bank);
        w.ld.addr = W_ADDR_W'(addr);
        w.ld.data = data;
        return w;
    endfunction

    function automatic logic [CMD_W-1:0] start_word(layer_e layer);
        cmd_word_u w;
        w.st.op    = OP_START;
        w.st.layer = layer;
        w.st.rsvd  = '0;
        return w;
    endfunction

    // Lane sum is the signed dot product of its bank slice and the window
    function automatic logic [ACC_W-1:0] model_sum(int lane, int base);
        int acc;
        acc = 0;
        for (int t = 0; t < TAP_CNT; t++) begin
            acc += int'($signed(w_mem[lane][base+t])) * int'($signed(act_mem[t]));
        end
        return ACC_W'(acc);
    endfunction

    // Called and left on a falling edge
    task automatic send_cmd(logic [CMD_W-1:0] word);
        cmd_valid_i = 1'b1;
        cmd_word_i  = word;
        while (!cmd_ready_o) @(negedge clk);
        @(negedge clk);
        cmd_valid_i = 1'b0;
    endtask

    task automatic load_weight(int bank, int addr, logic [DATA_W-1:0] data);
        w_mem[bank][addr] = data;
        send_cmd(load_word(OP_LOAD_W, bank, addr, data));
    endtask

    task automatic load_act(int idx, logic [DATA_W-1:0] data);
        act_mem[idx] = data;
        send_cmd(load_word(OP_LOAD_A, 0, idx, data));
    endtask

    task automatic run_pass(layer_e layer, logic random_ready);
        int base;
        int stray_addr;
        base       = (layer == LAYER_2) ? L2_BASE : 0;
        stray_addr = (layer == LAYER_2) ? 5 : L2_BASE + 5;
        for (int l = 0; l < NUM_LANES; l++) begin
            exp_sum[l] = model_sum(l, base);
        end
        exp_cnt    = (layer == LAYER_2) ? NUM_LANES : L1_LANES;
        rand_ready = random_ready;
        send_cmd(start_word(layer));
        // A stray weight write offered while busy would spoil the next pass
        cmd_valid_i = 1'b1;
        cmd_word_i  = load_word(OP_LOAD_W, 2, stray_addr, ~w_mem[2][stray_addr]);
        while (!cmd_ready_o) @(negedge clk);
        cmd_valid_i = 1'b0;
        a_pass_count: assert (exp_idx == exp_cnt) else begin
            err_proto++;
            $display("Pass for layer %0d ended after %0d of %0d results",
                     int'(layer) + 1, exp_idx, exp_cnt);
        end
    endtask

    assign start_acc = cmd_valid_i && cmd_ready_o && (cmd_word_i[CMD_W-1 -: 2] == OP_START);

    // Result bookkeeping
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_idx   <= 0;
            rx_cnt    <= 0;
            pass_busy <= 1'b0;
        end else if (start_acc) begin
            exp_idx   <= 0;
            pass_busy <= 1'b1;
        end else if (res_valid_o && res_ready_i) begin
            exp_idx <= exp_idx + 1;
            rx_cnt  <= rx_cnt + 1;
            if (exp_idx == exp_cnt - 1) begin
                pass_busy <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (rand_ready) begin
            rdy_rng     = xorshift32(rdy_rng);
            res_ready_i = rdy_rng[1:0] != 2'b00;
        end else begin
            res_ready_i = 1'b1;
        end
    end

    a_res_lane: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid_o && res_ready_i |-> exp_idx < exp_cnt && res_lane_o == LANE_W'(exp_idx))
        else begin
            err_proto++;
            $display("[FAIL] res_lane_o got=%0h exp=%0h", $sampled(res_lane_o), $sampled(exp_idx));
        end

    a_res_data: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid_o && res_ready_i |-> res_data_o == exp_sum[exp_idx])
        else begin
            err_data++;
            $display("[FAIL] res_data_o lane=%0h got=%0h exp=%0h", $sampled(res_lane_o),
                     $sampled(res_data_o), exp_sum[$sampled(exp_idx)]);
        end

    a_res_stall: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid_o && !res_ready_i |=>
            res_valid_o && $stable(res_lane_o) && $stable(res_data_o))
        else begin
            err_proto++;
            $display("[FAIL] res_data_o changed under stall lane=%0h data=%0h",
                     $sampled(res_lane_o), $sampled(res_data_o));
        end

    a_ready_low: assert property (@(posedge clk) disable iff (!rst_n)
        pass_busy |-> !cmd_ready_o)
        else begin
            err_proto++;
            $display("[FAIL] cmd_ready_o=%0h during pass", $sampled(cmd_ready_o));
        end

    // res_valid_o rises on the 29th edge after the accepting one
    a_first_latency: assert property (@(posedge clk) disable iff (!rst_n)
        start_acc |-> ##30 $rose(res_valid_o))
        else begin
            err_proto++;
            $display("[FAIL] res_valid_o=%0h not raised 29 cycles after start",
                     $sampled(res_valid_o));
        end

    a_reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> !res_valid_o && !cmd_ready_o)
        else begin
            err_proto++;
            $display("[FAIL] after reset res_valid_o=%0h cmd_ready_o=%0h",
                     $sampled(res_valid_o), $sampled(cmd_ready_o));
        end

    initial begin
        rst_n       = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_word_i  = '0;
        res_ready_i = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int b = 0; b < NUM_LANES; b++) begin
            for (int a = 0; a < 2 * TAP_CNT; a++) begin
                data_rng = xorshift32(data_rng);
                load_weight(b, a, data_rng[7:0]);
            end
        end
        for (int t = 0; t < TAP_CNT; t++) begin
            data_rng = xorshift32(data_rng);
            load_act(t, data_rng[7:0]);
        end

        run_pass(LAYER_1, 1'b0);
        run_pass(LAYER_2, 1'b1);
        rand_ready = 1'b0;
        data_rng = xorshift32(data_rng);
        load_weight(4, 7, data_rng[7:0]);
        load_act(11, data_rng[15:8]);
        run_pass(LAYER_1, 1'b1);
        run_pass(LAYER_2, 1'b1);
        @(negedge clk);

        $display("Done: %0d results, %0d data errors, %0d protocol errors",
                 rx_cnt, err_data, err_proto);
        if (err_data + err_proto == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (LIMIT_CYC) @(posedge clk);
        $display("Timeout: run still going after %0d cycles", LIMIT_CYC);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== compile.f ====
cnn_cfg_pkg.sv
cnn_cmd_pkg.sv
cnn_ifs.sv
cmd_decoder.sv
weight_banks.sv
weight_buffer.sv
mac_array.sv
result_drain.sv
cnn_conv_top.sv
tb_cnn_conv.sv

// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
FILELIST   ?= compile.f
RTL_TOP    ?= cnn_conv_top
TB_TOP     ?= tb_cnn_conv
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o $(TB_TOP)
	@out="$$(./$(OBJ_DIR)/$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
